/* Makefile */
VERILATOR ?= verilator
TOP ?= cache_tb
FILELIST ?= cache_subsys.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cache_subsys.f */
rtl/cache_pkg.sv
rtl/cache_way.sv
rtl/plru_tree.sv
rtl/cache_ctrl.sv
rtl/cache_4way.sv
rtl/line_mem.sv
rtl/cache_subsys.sv
dv/cache_checker.sv
dv/cache_tb.sv

/* dv/cache_checker.sv */
module cache_checker (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input cache_pkg::cpu_req_t req,
	input logic req_ready,
	input logic resp_valid,
	input cache_pkg::cpu_resp_t resp,
	output int error_count,
	output int resp_count
);
	timeunit 1ns;
	timeprecision 1ps;
	import cache_pkg::*;

	localparam int LINE_SEL_BITS = $clog2(MEM_LINES);

	line_t ref_mem [MEM_LINES]; // 1 KiB window seen through the cache
	logic [NUM_WAYS-1:0] ref_valid [NUM_INDEX];
	int ref_tag [NUM_INDEX][NUM_WAYS];
	logic [2:0] ref_tree [NUM_INDEX];
	cpu_resp_t expected;
	logic [ADDR_BITS-1:0] expected_addr;
	logic pending;
	logic idle_checked;
	int cycle;
	int accept_cycle;

	// Each 32-bit word starts out equal to its byte address
	initial begin
		for (int i = 0; i < MEM_LINES; i++) begin
			for (int w = 0; w < LINE_BITS / 32; w++)
				ref_mem[i][32*w +: 32] = 32'(LINE_BYTES * i + 4 * w);
		end
	end

	// Resident way for a tag, or -1
	function automatic int lookup_way(index_t idx, int tag);
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_valid[idx][w] && ref_tag[idx][w] == tag)
				return w;
		end
		return -1;
	endfunction

	function automatic int victim_way(index_t idx);
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (!ref_valid[idx][w])
				return w; // Lowest invalid way first
		end
		if (!ref_tree[idx][2])
			return ref_tree[idx][1] ? 1 : 0;
		return ref_tree[idx][0] ? 3 : 2;
	endfunction

	function automatic cpu_resp_t reference_response(cpu_req_t r);
		cpu_resp_t result;
		result.hit = lookup_way(r.addr[OFFSET_BITS +: INDEX_BITS],
			int'(r.addr[ADDR_BITS-1:OFFSET_BITS+INDEX_BITS])) >= 0;
		result.rdata = ref_mem[r.addr[OFFSET_BITS +: LINE_SEL_BITS]];
		for (int b = 0; b < LINE_BYTES; b++) begin
			if (r.write && r.byte_en[b])
				result.rdata[8*b +: 8] = r.wdata[8*b +: 8];
		end
		return result;
	endfunction

	function automatic void update_model(cpu_req_t r, cpu_resp_t exp_resp);
		index_t idx;
		int tag;
		int way;
		idx = r.addr[OFFSET_BITS +: INDEX_BITS];
		tag = int'(r.addr[ADDR_BITS-1:OFFSET_BITS+INDEX_BITS]);
		way = lookup_way(idx, tag);
		if (way < 0) begin
			way = victim_way(idx);
			ref_valid[idx][way] = 1'b1;
			ref_tag[idx][way] = tag;
		end
		// Root to the other half, leaf to the pair partner
		ref_tree[idx][2] = (way < 2);
		if (way < 2)
			ref_tree[idx][1] = (way == 0);
		else
			ref_tree[idx][0] = (way == 2);
		ref_mem[r.addr[OFFSET_BITS +: LINE_SEL_BITS]] = exp_resp.rdata;
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			error_count = 0;
			resp_count = 0;
			cycle = 0;
			pending = 1'b0;
			idle_checked = 1'b0;
			for (int i = 0; i < NUM_INDEX; i++) begin
				ref_valid[i] = '0;
				ref_tree[i] = '0;
			end
		end else begin
			cycle++;
			if (!idle_checked && (req_ready !== 1'b1 || resp_valid !== 1'b0)) begin
				error_count++;
				$display("** Error: req_ready = 0x%0h, resp_valid = 0x%0h after reset, %s",
					req_ready, resp_valid, "expected 0x1, 0x0");
			end
			idle_checked = 1'b1;
			// Ready stays low through the response cycle
			if (pending && req_ready !== 1'b0) begin
				error_count++;
				$display("** Error: req_ready = 0x%0h with a request outstanding, expected 0x0",
					req_ready);
			end
			if (resp_valid && !pending) begin
				error_count++;
				$display("Response at %0t with no request outstanding", $time);
			end else if (resp_valid) begin
				resp_count++;
				pending = 1'b0;
				if (resp.hit !== expected.hit) begin
					error_count++;
					$display("** Error: resp.hit = 0x%0h, expected 0x%0h (addr 0x%08h)",
						resp.hit, expected.hit, expected_addr);
				end
				if (resp.rdata !== expected.rdata) begin
					error_count++;
					$display("** Error: resp.rdata = 0x%032h, expected 0x%032h (addr 0x%08h)",
						resp.rdata, expected.rdata, expected_addr);
				end
				// Valid rises one edge after accept and is sampled at the next
				if (resp.hit && cycle - accept_cycle != 2) begin
					error_count++;
					$display("Hit at addr 0x%08h answered %0d cycles after acceptance, not 1",
						expected_addr, cycle - accept_cycle - 1);
				end
			end
			if (req_valid && req_ready) begin
				expected = reference_response(req);
				update_model(req, expected);
				expected_addr = req.addr;
				accept_cycle = cycle;
				pending = 1'b1;
			end
		end
	end

endmodule

/* dv/cache_tb.sv */
module cache_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import cache_pkg::*;

	localparam int NUM_DIRECTED = 20;
	localparam int NUM_RANDOM = 200;
	localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 40 + 100;
	localparam logic [15:0] LFSR_SEED = 16'd46;
	localparam logic [15:0] LFSR_TAPS = 16'hb400; // x^16 + x^14 + x^13 + x^11 + 1

	logic clk = 1'b0;
	logic reset;
	logic req_valid;
	cpu_req_t req;
	logic req_ready;
	logic resp_valid;
	cpu_resp_t resp;
	int error_count;
	int resp_count;
	int req_count;
	int tb_errors;
	logic [15:0] lfsr;

	always #5 clk = ~clk;

	cache_subsys cache_subsys_inst (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp(resp)
	);

	cache_checker checker_inst (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp(resp),
		.error_count(error_count),
		.resp_count(resp_count)
	);

	function automatic logic [15:0] lfsr_next(logic [15:0] state);
		return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
	endfunction

	task automatic random_bits(input int width, output line_t value);
		value = '0;
		for (int i = 0; i < width; i++) begin
			lfsr = lfsr_next(lfsr);
			value = {value[LINE_BITS-2:0], lfsr[0]};
		end
	endtask

	// Starts just after a rising edge, returns at the response edge
	task automatic issue_request(input logic [ADDR_BITS-1:0] req_addr, input logic req_write,
			input logic [LINE_BYTES-1:0] req_be, input line_t req_data);
		req <= '{addr: req_addr, write: req_write, byte_en: req_be, wdata: req_data};
		req_valid <= 1'b1;
		req_count++;
		@(posedge clk);
		while (!req_ready)
			@(posedge clk);
		req_valid <= 1'b0;
		@(posedge clk);
		while (!resp_valid)
			@(posedge clk);
	endtask

	task automatic read_line(input logic [ADDR_BITS-1:0] req_addr);
		issue_request(req_addr, 1'b0, '0, '0);
	endtask

	task automatic write_line(input logic [ADDR_BITS-1:0] req_addr,
			input logic [LINE_BYTES-1:0] req_be);
		line_t data;
		random_bits(LINE_BITS, data);
		issue_request(req_addr, 1'b1, req_be, data);
	endtask

	task automatic check_cold_reads();
		read_line(32'h000);
		read_line(32'h044); // Nonzero offset
		read_line(32'h3a0);
	endtask

	task automatic repeat_reads();
		read_line(32'h000);
		read_line(32'h040);
	endtask

	task automatic merge_byte_writes();
		write_line(32'h000, 16'ha50f); // Hit
		read_line(32'h000);
		write_line(32'h200, 16'h0180); // Miss, merged into the fill
		read_line(32'h200);
	endtask

	// A to E share index 3, rereading A leaves the tree on way 2
	task automatic evict_dirty_victim();
		for (int i = 0; i < 4; i++)
			write_line(32'h030 + 32'(64 * i), 16'hffff);
		read_line(32'h030);
		read_line(32'h130); // E evicts dirty C
		read_line(32'h030);
		read_line(32'h070);
		read_line(32'h0f0);
		read_line(32'h0b0); // C comes back from line_mem
		read_line(32'h0b0);
	endtask

	task automatic random_traffic();
		line_t bits;
		line_t data;
		logic [ADDR_BITS-1:0] addr;
		logic write;
		logic [LINE_BYTES-1:0] byte_en;
		for (int i = 0; i < NUM_RANDOM; i++) begin
			random_bits(10, bits);
			addr = 32'(bits[9:0]);
			random_bits(1, bits);
			write = bits[0];
			random_bits(LINE_BYTES, bits);
			byte_en = bits[LINE_BYTES-1:0];
			random_bits(LINE_BITS, data);
			issue_request(addr, write, byte_en, data);
		end
	endtask

	task automatic print_summary();
		$display("Summary: %0d requests, %0d responses checked, %0d errors",
			req_count, resp_count, error_count + tb_errors);
	endtask

	initial begin
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		lfsr = LFSR_SEED;
		req_count = 0;
		tb_errors = 0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		check_cold_reads();
		repeat_reads();
		merge_byte_writes();
		evict_dirty_victim();
		random_traffic();
		repeat (4) @(posedge clk);
		@(negedge clk);
		if (resp_count != req_count) begin
			tb_errors++;
			$display("Got %0d responses for %0d requests", resp_count, req_count);
		end
		print_summary();
		if (error_count + tb_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		print_summary();
		$display("** FAIL **");
		$finish;
	end

endmodule

/* rtl/cache_4way.sv */
module cache_4way (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input cache_pkg::cpu_req_t req,
	input logic mem_ack,
	input cache_pkg::line_t mem_rdata,
	output logic req_ready,
	output logic resp_valid,
	output cache_pkg::cpu_resp_t resp,
	output logic mem_req_valid,
	output cache_pkg::mem_req_t mem_req
);
	import cache_pkg::*;

	logic [ADDR_BITS-1:0] addr_q;
	tag_t lookup_tag;
	index_t lookup_index;
	tag_t fill_tag;
	index_t fill_index;
	logic [NUM_WAYS-1:0] way_hit;
	logic [NUM_WAYS-1:0] way_valid;
	logic [NUM_WAYS-1:0] way_dirty;
	tag_t [NUM_WAYS-1:0] way_tag;
	line_t [NUM_WAYS-1:0] way_line;
	way_sel_t way_wr;
	way_sel_t way_fill;
	way_sel_t victim;
	way_sel_t touch_way;
	logic touch;
	logic [LINE_BYTES-1:0] wr_byte_en;
	line_t wr_data;

	// Lookup address held for the whole transaction
	always_ff @(posedge clk) begin
		if (req_valid && req_ready)
			addr_q <= req.addr;
	end

	assign lookup_tag = addr_q[ADDR_BITS-1 -: TAG_BITS];
	assign lookup_index = addr_q[OFFSET_BITS +: INDEX_BITS];

	// Fill target comes from the outstanding memory read
	assign fill_tag = mem_req.addr[ADDR_BITS-1 -: TAG_BITS];
	assign fill_index = mem_req.addr[OFFSET_BITS +: INDEX_BITS];

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		cache_way way_inst (
			.clk(clk),
			.reset(reset),
			.index(lookup_index),
			.tag(lookup_tag),
			.wr_en(way_wr[w]),
			.byte_en(wr_byte_en),
			.wdata(wr_data),
			.fill_en(way_fill[w]),
			.fill_index(fill_index),
			.fill_tag(fill_tag),
			.fill_data(mem_rdata),
			.hit(way_hit[w]),
			.valid(way_valid[w]),
			.dirty(way_dirty[w]),
			.way_tag(way_tag[w]),
			.way_line(way_line[w])
		);
	end

	plru_tree plru_inst (
		.clk(clk),
		.reset(reset),
		.index(lookup_index),
		.touch(touch),
		.touch_way(touch_way),
		.victim(victim)
	);

	cache_ctrl ctrl_inst (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.way_hit(way_hit),
		.way_valid(way_valid),
		.way_dirty(way_dirty),
		.way_tag(way_tag),
		.way_line(way_line),
		.victim(victim),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp(resp),
		.way_wr(way_wr),
		.way_fill(way_fill),
		.wr_byte_en(wr_byte_en),
		.wr_data(wr_data),
		.touch(touch),
		.touch_way(touch_way),
		.mem_req_valid(mem_req_valid),
		.mem_req(mem_req)
	);

endmodule

/* rtl/cache_ctrl.sv */
module cache_ctrl (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input cache_pkg::cpu_req_t req,
	input logic [cache_pkg::NUM_WAYS-1:0] way_hit,
	input logic [cache_pkg::NUM_WAYS-1:0] way_valid,
	input logic [cache_pkg::NUM_WAYS-1:0] way_dirty,
	input cache_pkg::tag_t [cache_pkg::NUM_WAYS-1:0] way_tag,
	input cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] way_line,
	input cache_pkg::way_sel_t victim,
	input logic mem_ack,
	input cache_pkg::line_t mem_rdata,
	output logic req_ready,
	output logic resp_valid,
	output cache_pkg::cpu_resp_t resp,
	output cache_pkg::way_sel_t way_wr,
	output cache_pkg::way_sel_t way_fill,
	output logic [cache_pkg::LINE_BYTES-1:0] wr_byte_en,
	output cache_pkg::line_t wr_data,
	output logic touch,
	output cache_pkg::way_sel_t touch_way,
	output logic mem_req_valid,
	output cache_pkg::mem_req_t mem_req
);
	import cache_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_LOOKUP, S_WRITEBACK, S_FILL, S_RESPOND} state_t;

	state_t state;
	cpu_req_t req_q;
	way_sel_t victim_q;
	way_sel_t chosen;
	logic hit_any;
	logic chosen_dirty;
	tag_t chosen_tag;
	line_t chosen_line;
	line_t hit_line;
	line_t resp_base;
	line_t resp_line;
	mem_req_t fill_req;
	mem_req_t wb_req;

	function automatic line_t merge_line(line_t base, line_t data,
			logic [LINE_BYTES-1:0] be);
		line_t result;
		result = base;
		for (int b = 0; b < LINE_BYTES; b++) begin
			if (be[b])
				result[8*b +: 8] = data[8*b +: 8];
		end
		return result;
	endfunction

	assign hit_any = |way_hit;

	// Invalid way first, lowest number wins, else the tree
	always_comb begin
		chosen = victim;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (!way_valid[w])
				chosen = way_sel_t'(1 << w);
		end
	end

	always_comb begin
		chosen_dirty = 1'b0;
		chosen_tag = '0;
		chosen_line = '0;
		hit_line = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (chosen[w]) begin
				chosen_dirty = way_valid[w] && way_dirty[w];
				chosen_tag = way_tag[w];
				chosen_line = way_line[w];
			end
			if (way_hit[w])
				hit_line = way_line[w];
		end
	end

	// Miss path returns the fresh line, hit path the resident one
	assign resp_base = (state == S_FILL) ? mem_rdata : hit_line;
	assign resp_line = req_q.write ?
		merge_line(resp_base, req_q.wdata, req_q.byte_en) : resp_base;

	assign fill_req = '{addr: {req_q.addr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}},
		write: 1'b0, wdata: '0};
	assign wb_req = '{addr: {chosen_tag, req_q.addr[OFFSET_BITS +: INDEX_BITS],
		{OFFSET_BITS{1'b0}}}, write: 1'b1, wdata: chosen_line};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			mem_req_valid <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (req_valid) state <= S_LOOKUP;
				S_LOOKUP: begin
					if (hit_any) begin
						state <= S_RESPOND;
					end else begin
						state <= chosen_dirty ? S_WRITEBACK : S_FILL;
						mem_req_valid <= 1'b1;
					end
				end
				S_WRITEBACK: begin
					if (mem_ack) begin
						mem_req_valid <= 1'b0; // Drop for a cycle before the fill
						state <= S_FILL;
					end
				end
				S_FILL: begin
					if (mem_ack) begin
						mem_req_valid <= 1'b0;
						state <= S_RESPOND;
					end else if (!mem_req_valid) begin
						mem_req_valid <= 1'b1;
					end
				end
				S_RESPOND: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && req_valid)
			req_q <= req;
		if (state == S_LOOKUP) begin
			victim_q <= chosen;
			resp.rdata <= resp_line;
			resp.hit <= hit_any;
			mem_req <= chosen_dirty ? wb_req : fill_req;
		end
		if (state == S_WRITEBACK && mem_ack)
			mem_req <= fill_req;
		if (state == S_FILL && mem_ack)
			resp.rdata <= resp_line;
	end

	assign req_ready = (state == S_IDLE);
	assign resp_valid = (state == S_RESPOND);

	// Miss writes land one cycle after the fill
	always_comb begin
		way_wr = '0;
		if (state == S_LOOKUP && hit_any && req_q.write)
			way_wr = way_hit;
		else if (state == S_RESPOND && !resp.hit && req_q.write)
			way_wr = victim_q;
	end

	assign way_fill = (state == S_FILL && mem_ack) ? victim_q : '0;
	assign wr_byte_en = req_q.byte_en;
	assign wr_data = req_q.wdata;

	assign touch = (state == S_LOOKUP && hit_any) || (state == S_RESPOND && !resp.hit);
	assign touch_way = (state == S_LOOKUP) ? way_hit : victim_q;

	a_mem_req_stable: assert property (@(posedge clk) disable iff (reset)
		mem_req_valid && !mem_ack |=> $stable(mem_req))
		else $error("cache_ctrl: mem_req changed before ack");

	a_single_hit: assert property (@(posedge clk) disable iff (reset)
		$onehot0(way_hit))
		else $error("cache_ctrl: multiple way hits %b", way_hit);

endmodule

/* rtl/cache_pkg.sv */
package cache_pkg;

	// Line and address geometry
	localparam int ADDR_BITS = 32;
	localparam int LINE_BITS = 128;
	localparam int LINE_BYTES = LINE_BITS / 8;
	localparam int OFFSET_BITS = $clog2(LINE_BYTES);
	localparam int NUM_INDEX = 4;
	localparam int INDEX_BITS = $clog2(NUM_INDEX);
	localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS - INDEX_BITS;
	localparam int NUM_WAYS = 4;

	// Backing store
	localparam int MEM_LINES = 64;
	localparam int MEM_LATENCY = 3; // Request seen to ack

	typedef logic [LINE_BITS-1:0] line_t;
	typedef logic [TAG_BITS-1:0] tag_t;
	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [NUM_WAYS-1:0] way_sel_t; // One-hot

	typedef struct packed {
		logic [ADDR_BITS-1:0] addr;
		logic write;
		logic [LINE_BYTES-1:0] byte_en;
		line_t wdata;
	} cpu_req_t;

	typedef struct packed {
		line_t rdata;
		logic hit;
	} cpu_resp_t;

	// Address is always line aligned
	typedef struct packed {
		logic [ADDR_BITS-1:0] addr;
		logic write;
		line_t wdata;
	} mem_req_t;

endpackage

/* rtl/cache_subsys.sv */
module cache_subsys (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input cache_pkg::cpu_req_t req,
	output logic req_ready,
	output logic resp_valid,
	output cache_pkg::cpu_resp_t resp
);
	import cache_pkg::*;

	logic mem_req_valid;
	mem_req_t mem_req;
	logic mem_ack;
	line_t mem_rdata;

	cache_4way cache_inst (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp(resp),
		.mem_req_valid(mem_req_valid),
		.mem_req(mem_req)
	);

	line_mem mem_inst (
		.clk(clk),
		.reset(reset),
		.mem_req_valid(mem_req_valid),
		.mem_req(mem_req),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

endmodule

/* rtl/cache_way.sv */
module cache_way (
	input logic clk,
	input logic reset,
	input cache_pkg::index_t index,
	input cache_pkg::tag_t tag,
	input logic wr_en,
	input logic [cache_pkg::LINE_BYTES-1:0] byte_en,
	input cache_pkg::line_t wdata,
	input logic fill_en,
	input cache_pkg::index_t fill_index,
	input cache_pkg::tag_t fill_tag,
	input cache_pkg::line_t fill_data,
	output logic hit,
	output logic valid,
	output logic dirty,
	output cache_pkg::tag_t way_tag,
	output cache_pkg::line_t way_line
);
	import cache_pkg::*;

	logic [NUM_INDEX-1:0] valid_bits;
	logic [NUM_INDEX-1:0] dirty_bits;
	tag_t tags [NUM_INDEX];
	line_t lines [NUM_INDEX];

	// Lookup at the addressed index
	assign valid = valid_bits[index];
	assign dirty = dirty_bits[index];
	assign way_tag = tags[index];
	assign way_line = lines[index];
	assign hit = valid_bits[index] && (tags[index] == tag);

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (fill_en) begin
			valid_bits[fill_index] <= 1'b1;
			dirty_bits[fill_index] <= 1'b0; // Fresh from memory
		end else if (wr_en) begin
			dirty_bits[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en) begin
			tags[fill_index] <= fill_tag;
			lines[fill_index] <= fill_data;
		end else if (wr_en) begin
			// Byte merge into the resident line
			for (int b = 0; b < LINE_BYTES; b++) begin
				if (byte_en[b])
					lines[index][8*b +: 8] <= wdata[8*b +: 8];
			end
		end
	end

	// Controller must never fill and write the same way at once
	a_no_wr_fill: assert property (@(posedge clk) disable iff (reset)
		!(wr_en && fill_en))
		else $error("cache_way: wr_en and fill_en both high");

endmodule

/* rtl/line_mem.sv */
module line_mem (
	input logic clk,
	input logic reset,
	input logic mem_req_valid,
	input cache_pkg::mem_req_t mem_req,
	output logic mem_ack,
	output cache_pkg::line_t mem_rdata
);
	import cache_pkg::*;

	line_t lines [MEM_LINES];
	logic [$clog2(MEM_LINES)-1:0] line_index;
	logic [$clog2(MEM_LATENCY)-1:0] count;
	logic fire;

	// Bits above 9 ignored
	assign line_index = mem_req.addr[OFFSET_BITS +: $clog2(MEM_LINES)];
	assign fire = mem_req_valid && !mem_ack && (int'(count) == MEM_LATENCY - 1);

	// Every 32-bit word holds its own byte address
	initial begin
		for (int i = 0; i < MEM_LINES; i++) begin
			for (int w = 0; w < LINE_BITS / 32; w++)
				lines[i][32*w +: 32] = 32'(i * LINE_BYTES + 4 * w);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			mem_ack <= 1'b0;
		end else if (fire) begin
			count <= '0;
			mem_ack <= 1'b1;
		end else if (mem_req_valid && !mem_ack) begin
			count <= count + 1'b1;
		end else begin
			count <= '0;
			mem_ack <= 1'b0; // Single-cycle ack
		end
	end

	always @(posedge clk) begin
		if (fire) begin
			if (mem_req.write)
				lines[line_index] <= mem_req.wdata;
			mem_rdata <= lines[line_index];
		end
	end

endmodule

/* rtl/plru_tree.sv */
module plru_tree (
	input logic clk,
	input logic reset,
	input cache_pkg::index_t index,
	input logic touch,
	input cache_pkg::way_sel_t touch_way,
	output cache_pkg::way_sel_t victim
);
	import cache_pkg::*;

	// Bit 2 root (0 = ways 0/1), bit 1 left leaf, bit 0 right leaf
	logic [NUM_INDEX-1:0][2:0] tree;
	logic [2:0] cur;

	assign cur = tree[index];

	always_comb begin
		victim = '0;
		if (!cur[2])
			victim[cur[1] ? 1 : 0] = 1'b1;
		else
			victim[cur[0] ? 3 : 2] = 1'b1;
	end

	// Point away from the way just used
	always_ff @(posedge clk) begin
		if (reset) begin
			tree <= '0;
		end else if (touch) begin
			case (touch_way)
				4'b0001: tree[index] <= {2'b11, cur[0]};
				4'b0010: tree[index] <= {2'b10, cur[0]};
				4'b0100: tree[index] <= {1'b0, cur[1], 1'b1};
				4'b1000: tree[index] <= {1'b0, cur[1], 1'b0};
				default: tree[index] <= cur;
			endcase
		end
	end

	a_touch_onehot: assert property (@(posedge clk) disable iff (reset)
		touch |-> $onehot(touch_way))
		else $error("plru_tree: touch_way not one-hot (%b)", touch_way);

endmodule
